/* rtcDisplayPkg.sv */
`default_nettype none

package rtcDisplayPkg;

    ////////////////////////////////////////
    // VGA 640x480 timing, one pixel per clk
    ////////////////////////////////////////

    // Horizontal, in pixels
    parameter int hVisible = 640;
    parameter int hFront   = 16;
    parameter int hSync    = 96;
    parameter int hBack    = 48;
    parameter int hTotal   = hVisible + hFront + hSync + hBack; // 800

    // Vertical, in lines
    parameter int vVisible = 480;
    parameter int vFront   = 10;
    parameter int vSync    = 2;
    parameter int vBack    = 33;
    parameter int vTotal   = vVisible + vFront + vSync + vBack; // 525

    typedef logic [9:0]  pixelCoord;     // Screen x or y
    typedef logic [6:0]  asciiCode;      // Low nibble doubles as glyph index
    typedef logic [11:0] rgbColor;       // 4 bits each R, G, B

    parameter rgbColor textColor = 12'hFFF; // White text on black

    parameter int fieldCount = 6;        // sec, min, hour, date, month, year
    parameter int glyphRows  = 8;        // 8x8 font

endpackage

`default_nettype wire

/* vgaSync.sv */
`timescale 1ns/1ps
`default_nettype none

module vgaSync import rtcDisplayPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    output pixelCoord pixelX,
    output pixelCoord pixelY,
    output logic      videoOn,
    output logic      hsync,
    output logic      vsync,
    output logic      frameBlank
);

    pixelCoord hCount;   // Pixel within line
    pixelCoord vCount;   // Line within frame
    logic      hEnd;     // Last pixel of line
    logic      vEnd;     // Last line of frame

    assign hEnd = (hCount == pixelCoord'(hTotal - 1));
    assign vEnd = (vCount == pixelCoord'(vTotal - 1));

    ////////////////////////////////////////
    // Scan counters
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hCount <= '0;
            vCount <= '0;
        end else if (hEnd) begin
            hCount <= '0;
            vCount <= vEnd ? '0 : vCount + 1'b1; // Step line at end of each row
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Decode from counters
    ////////////////////////////////////////

    assign pixelX = hCount;
    assign pixelY = vCount;

    assign videoOn = (hCount < pixelCoord'(hVisible)) && (vCount < pixelCoord'(vVisible));

    // Sync pulses sit between front and back porch, active low
    assign hsync = !((hCount >= pixelCoord'(hVisible + hFront)) &&
                     (hCount <  pixelCoord'(hVisible + hFront + hSync)));
    assign vsync = !((vCount >= pixelCoord'(vVisible + vFront)) &&
                     (vCount <  pixelCoord'(vVisible + vFront + vSync)));

    assign frameBlank = (vCount >= pixelCoord'(vVisible)); // Whole vertical blanking

endmodule

`default_nettype wire

/* rtcCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module rtcCapture import rtcDisplayPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       frameBlank,
    input  logic       rtcValid,
    input  logic [7:0] rtcData,
    output asciiCode   secTens,
    output asciiCode   secUnits,
    output asciiCode   minTens,
    output asciiCode   minUnits,
    output asciiCode   hourTens,
    output asciiCode   hourUnits,
    output asciiCode   dateTens,
    output asciiCode   dateUnits,
    output asciiCode   monthTens,
    output asciiCode   monthUnits,
    output asciiCode   yearTens,
    output asciiCode   yearUnits
);

    logic       blankPrev;     // frameBlank one cycle back
    logic       blankRise;     // Start of vertical blanking
    logic [2:0] fieldCnt;      // Fields taken this blanking
    logic [2:0] curCnt;        // Count seen by this cycle
    logic       accept;        // Byte taken this cycle
    logic       commitPend;    // Sixth field just staged
    logic [3:0] tensVal;       // Decimal digits of rtcData
    logic [3:0] unitsVal;

    asciiCode stageTens  [fieldCount];  // Filled during blanking
    asciiCode stageUnits [fieldCount];
    asciiCode dispTens   [fieldCount];  // What the screen shows
    asciiCode dispUnits  [fieldCount];

    function automatic asciiCode toAscii(input logic [3:0] digit);
        return asciiCode'(7'h30 + {3'b000, digit}); // '0' + digit
    endfunction

    always_comb begin
        blankRise = frameBlank & ~blankPrev;
        curCnt    = blankRise ? 3'd0 : fieldCnt;  // New sequence restarts at slot 0
        accept    = frameBlank & rtcValid & (curCnt < 3'(fieldCount));
        tensVal   = 4'((rtcData / 8'd10) % 8'd10);
        unitsVal  = 4'(rtcData % 8'd10);
    end

    ////////////////////////////////////////
    // Count, stage, commit
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            blankPrev  <= 1'b0;
            fieldCnt   <= '0;
            commitPend <= 1'b0;
            for (int i = 0; i < fieldCount; i++) begin
                stageTens[i]  <= 7'h30;
                stageUnits[i] <= 7'h30;
                dispTens[i]   <= 7'h30;
                dispUnits[i]  <= 7'h30;
            end
        end else begin
            blankPrev  <= frameBlank;
            fieldCnt   <= accept ? curCnt + 1'b1 : curCnt;
            commitPend <= accept && (curCnt == 3'(fieldCount - 1)); // Last field in
            if (accept) begin
                stageTens[curCnt]  <= toAscii(tensVal);
                stageUnits[curCnt] <= toAscii(unitsVal);
            end
            if (commitPend) begin
                for (int i = 0; i < fieldCount; i++) begin
                    dispTens[i]  <= stageTens[i];   // All fields switch together
                    dispUnits[i] <= stageUnits[i];
                end
            end
        end
    end

    // Slot order follows RTC field order
    assign secTens    = dispTens[0];
    assign secUnits   = dispUnits[0];
    assign minTens    = dispTens[1];
    assign minUnits   = dispUnits[1];
    assign hourTens   = dispTens[2];
    assign hourUnits  = dispUnits[2];
    assign dateTens   = dispTens[3];
    assign dateUnits  = dispUnits[3];
    assign monthTens  = dispTens[4];
    assign monthUnits = dispUnits[4];
    assign yearTens   = dispTens[5];
    assign yearUnits  = dispUnits[5];

endmodule

`default_nettype wire

/* textRenderer.sv */
`timescale 1ns/1ps
`default_nettype none

module textRenderer import rtcDisplayPkg::*; #(
    parameter pixelCoord textOriginX = 10'd288,
    parameter pixelCoord textOriginY = 10'd232
) (
    input  logic      clk,
    input  logic      rstN,
    input  pixelCoord pixelX,
    input  pixelCoord pixelY,
    input  logic      videoOn,
    input  logic      hsyncIn,
    input  logic      vsyncIn,
    input  asciiCode  secTens,
    input  asciiCode  secUnits,
    input  asciiCode  minTens,
    input  asciiCode  minUnits,
    input  asciiCode  hourTens,
    input  asciiCode  hourUnits,
    input  asciiCode  dateTens,
    input  asciiCode  dateUnits,
    input  asciiCode  monthTens,
    input  asciiCode  monthUnits,
    input  asciiCode  yearTens,
    input  asciiCode  yearUnits,
    output rgbColor   rgb,
    output logic      hsync,
    output logic      vsync
);

    localparam int       blockW    = 8 * glyphRows;   // 8 characters, square glyphs
    localparam int       blockH    = 2 * glyphRows;   // 2 text rows
    localparam int       romDepth  = 11 * glyphRows;  // Digits plus colon
    localparam asciiCode colonCode = 7'h3A;
    localparam asciiCode spaceCode = 7'h20;

    logic [7:0] glyphRom [romDepth];
    initial $readmemh("fontGlyphs.mem", glyphRom);

    pixelCoord  relX, relY;       // Offset inside text block
    logic       inBlock;
    asciiCode   charCode;
    logic [6:0] romAddr;          // index*8 + glyph row
    logic [7:0] glyphWord;        // Stage 1 ROM word
    logic [2:0] bitCol1;          // Stage 1 pixel column
    logic       blank1, videoOn1, hsync1, vsync1;

    always_comb begin
        relX    = pixelX - textOriginX;
        relY    = pixelY - textOriginY;
        inBlock = (pixelX >= textOriginX) && (relX < pixelCoord'(blockW)) &&
                  (pixelY >= textOriginY) && (relY < pixelCoord'(blockH));
        charCode = spaceCode;
        if (inBlock) begin
            case ({relY[3], relX[5:3]})  // Text row, character column
                4'd0:  charCode = hourTens;
                4'd1:  charCode = hourUnits;
                4'd2:  charCode = colonCode;
                4'd3:  charCode = minTens;
                4'd4:  charCode = minUnits;
                4'd5:  charCode = colonCode;
                4'd6:  charCode = secTens;
                4'd7:  charCode = secUnits;
                4'd8:  charCode = dateTens;
                4'd9:  charCode = dateUnits;
                4'd10: charCode = spaceCode;   // Blank separator
                4'd11: charCode = monthTens;
                4'd12: charCode = monthUnits;
                4'd13: charCode = spaceCode;
                4'd14: charCode = yearTens;
                4'd15: charCode = yearUnits;
            endcase
        end
        romAddr = {charCode[3:0], relY[2:0]};
    end

    ////////////////////////////////////////
    // Stage 1 ROM read, stage 2 color
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        glyphWord <= glyphRom[romAddr];
        bitCol1   <= relX[2:0];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            blank1   <= 1'b1;
            videoOn1 <= 1'b0;
            hsync1   <= 1'b1;
            vsync1   <= 1'b1;
            rgb      <= '0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
        end else begin
            blank1   <= (charCode[6:4] == 3'h2);  // Space draws nothing
            videoOn1 <= videoOn;
            hsync1   <= hsyncIn;
            vsync1   <= vsyncIn;
            rgb      <= (glyphWord[~bitCol1] && !blank1 && videoOn1) ? textColor : '0; // Bit 7 leftmost
            hsync    <= hsync1;   // Syncs ride along with pixel
            vsync    <= vsync1;
        end
    end

endmodule

`default_nettype wire

/* rtcDisplay.sv */
`timescale 1ns/1ps
`default_nettype none

module rtcDisplay import rtcDisplayPkg::*; #(
    parameter pixelCoord textOriginX = 10'd288,  // Centers 64x16 block
    parameter pixelCoord textOriginY = 10'd232
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       rtcValid,
    input  logic [7:0] rtcData,
    output rgbColor    rgb,
    output logic       hsync,
    output logic       vsync
);

    pixelCoord pixelX, pixelY;
    logic      videoOn, hsyncRaw, vsyncRaw, frameBlank;
    asciiCode  secTens, secUnits, minTens, minUnits, hourTens, hourUnits;
    asciiCode  dateTens, dateUnits, monthTens, monthUnits, yearTens, yearUnits;

    vgaSync scanGen (
        .clk(clk), .rstN(rstN), .pixelX(pixelX), .pixelY(pixelY), .videoOn(videoOn),
        .hsync(hsyncRaw), .vsync(vsyncRaw), .frameBlank(frameBlank)
    );

    rtcCapture capture (
        .clk(clk), .rstN(rstN), .frameBlank(frameBlank), .rtcValid(rtcValid),
        .rtcData(rtcData), .secTens(secTens), .secUnits(secUnits), .minTens(minTens),
        .minUnits(minUnits), .hourTens(hourTens), .hourUnits(hourUnits),
        .dateTens(dateTens), .dateUnits(dateUnits), .monthTens(monthTens),
        .monthUnits(monthUnits), .yearTens(yearTens), .yearUnits(yearUnits)
    );

    textRenderer #(.textOriginX(textOriginX), .textOriginY(textOriginY)) renderer (
        .clk(clk), .rstN(rstN), .pixelX(pixelX), .pixelY(pixelY), .videoOn(videoOn),
        .hsyncIn(hsyncRaw), .vsyncIn(vsyncRaw), .secTens(secTens), .secUnits(secUnits),
        .minTens(minTens), .minUnits(minUnits), .hourTens(hourTens),
        .hourUnits(hourUnits), .dateTens(dateTens), .dateUnits(dateUnits),
        .monthTens(monthTens), .monthUnits(monthUnits), .yearTens(yearTens),
        .yearUnits(yearUnits), .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

endmodule

`default_nettype wire

/* tbRtcDisplay.sv */
`timescale 1ns/1ps
`default_nettype none

module tbRtcDisplay import rtcDisplayPkg::*; ();

    localparam pixelCoord originX    = 10'd288;
    localparam pixelCoord originY    = 10'd232;
    localparam int        clkPeriod  = 40;
    localparam int        blockWidth = 8 * 8;                       // 8 chars of 8 pixels
    localparam int        watchdogCycles = 6 * vTotal * hTotal + 20000; // 6 frames plus slack

    logic       clk;
    logic       rstN;
    logic       rtcValid;
    logic [7:0] rtcData;
    rgbColor    rgb;
    logic       hsync;
    logic       vsync;

    logic [7:0] font [11 * glyphRows];                 // Own copy of the glyph file
    int         shown [fieldCount] = '{default: 0};    // Expected fields, RTC order
    string      testName = "sync lock";

    // Scan position, rebuilt from the DUT sync outputs
    int      hPos = 0;
    int      vPos = 0;
    logic    hsyncPrev = 1'b1;
    logic    vsyncPrev = 1'b1;
    logic    hRise = 1'b0;
    logic    vRise = 1'b0;
    logic    hOnce = 1'b0;
    logic    hTwice = 1'b0;
    logic    vOnce = 1'b0;
    logic    vTwice = 1'b0;
    logic    locked = 1'b0;          // Both positions known
    int      hLowCnt = 0;
    int      hGapCnt = 0;
    int      hLowLen = 0;
    int      hGap = 0;
    int      vLowCnt = 0;
    int      vGapCnt = 0;
    int      vLowLen = 0;
    int      vGap = 0;
    rgbColor rgbSeen = '0;           // rgb at the same sample as hPos, vPos
    rgbColor expRgb;

    rtcDisplay #(.textOriginX(originX), .textOriginY(originY)) DUT (
        .clk(clk), .rstN(rstN), .rtcValid(rtcValid), .rtcData(rtcData),
        .rgb(rgb), .hsync(hsync), .vsync(vsync)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // Scan tracking and reference model
    ////////////////////////////////////////

    always @(negedge clk) begin             // Outputs are stable mid-cycle
        hsyncPrev <= hsync;
        vsyncPrev <= vsync;
        hRise     <= hsync && !hsyncPrev;
        vRise     <= vsync && !vsyncPrev;
        rgbSeen   <= rgb;
        if (hsync && !hsyncPrev) begin      // First pixel of back porch
            hPos    <= hVisible + hFront + hSync;
            hLowLen <= hLowCnt;
            hGap    <= hGapCnt;
            hLowCnt <= 0;
            hGapCnt <= 1;
            hOnce   <= 1'b1;
            hTwice  <= hOnce;
        end else begin
            hPos    <= (hPos == hTotal - 1) ? 0 : hPos + 1;
            hLowCnt <= hLowCnt + (hsync ? 0 : 1);
            hGapCnt <= hGapCnt + 1;
        end
        if (vsync && !vsyncPrev) begin      // First line of back porch
            vPos    <= vVisible + vFront + vSync;
            vLowLen <= vLowCnt;
            vGap    <= vGapCnt;
            vLowCnt <= 0;
            vGapCnt <= 1;
            vOnce   <= 1'b1;
            vTwice  <= vOnce;
            locked  <= locked || hOnce;
        end else begin
            if (hPos == hTotal - 1)
                vPos <= (vPos == vTotal - 1) ? 0 : vPos + 1; // Line wraps
            vLowCnt <= vLowCnt + (vsync ? 0 : 1);
            vGapCnt <= vGapCnt + 1;
        end
    end

    // Glyph index of a text cell, -1 when blank
    function automatic int cellGlyph(input int row, input int col);
        int value;
        if (col == 2 || col == 5)
            return (row == 0) ? 10 : -1;    // Colon on time row, gap on date row
        value = (row == 0) ? shown[3'(2 - col / 3)] : shown[3'(3 + col / 3)];
        return (col % 3 == 0) ? (value / 10) % 10 : value % 10;
    endfunction

    function automatic rgbColor pixelColor(input int x, input int y);
        int         relX;
        int         relY;
        int         glyph;
        logic [7:0] bits;
        relX = x - int'(originX);
        relY = y - int'(originY);
        if (x >= hVisible || y >= vVisible)
            return '0;                      // Blanking stays black
        if (relX < 0 || relX >= blockWidth || relY < 0 || relY >= 2 * glyphRows)
            return '0;
        glyph = cellGlyph(relY / glyphRows, relX / 8);
        if (glyph < 0)
            return '0;
        bits = font[7'(glyph * glyphRows + relY % glyphRows)];
        return bits[3'(7 - relX % 8)] ? textColor : '0; // Bit 7 leftmost
    endfunction

    always_comb expRgb = pixelColor(hPos, vPos);

    task automatic failCheck(input string name, input string what, input int expV,
                             input int actV);
        $display("[ERROR] %s, %s: expected %0d, actual %0d", name, what, expV, actV);
        $display("test failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    hsyncLow: assert property (@(posedge clk) (hRise && hTwice) |-> (hLowLen == hSync))
        else failCheck("sync timing", "hsync low cycles", hSync, hLowLen);
    hsyncPeriod: assert property (@(posedge clk) (hRise && hTwice) |-> (hGap == hTotal))
        else failCheck("sync timing", "hsync period", hTotal, hGap);
    vsyncLow: assert property (@(posedge clk) (vRise && vTwice) |-> (vLowLen == vSync * hTotal))
        else failCheck("sync timing", "vsync low cycles", vSync * hTotal, vLowLen);
    vsyncPeriod: assert property (@(posedge clk) (vRise && vTwice) |-> (vGap == vTotal * hTotal))
        else failCheck("sync timing", "vsync period", vTotal * hTotal, vGap);
    pixelMatch: assert property (@(posedge clk) locked |-> (rgbSeen == expRgb))
        else failCheck(testName, $sformatf("rgb at (%0d,%0d)", hPos, vPos),
                       int'(expRgb), int'(rgbSeen));

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // First pixel of line y on the tracked output scan
    task automatic waitLine(input int y);
        do begin
            @(negedge clk);
        end while (!(locked && vPos == y && hPos == 0));
    endtask

    task automatic sendBytes(input int vals[$]);
        foreach (vals[i]) begin
            @(posedge clk);
            #2;
            rtcValid = 1'b1;
            rtcData  = 8'(vals[i]);
        end
        @(posedge clk);
        #2;
        rtcValid = 1'b0;
    endtask

    // Screen takes the first six of a full sequence
    task automatic expectFields(input int vals[$]);
        for (int i = 0; i < fieldCount; i++)
            shown[3'(i)] = vals[i];
    endtask

    initial begin
        int vals[$];
        void'($urandom(32'h0c95_857c));
        rstN     = 1'b0;
        rtcValid = 1'b0;
        rtcData  = '0;
        $readmemh("fontGlyphs.mem", font);
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;

        do begin
            @(negedge clk);
        end while (!locked);
        testName = "reset content";
        waitLine(vVisible);                 // Next frame shows all zeros

        testName = "full update";
        repeat (6) vals.push_back(int'($urandom_range(99, 0)));
        sendBytes(vals);
        expectFields(vals);
        waitLine(vVisible);

        testName = "incomplete sequence";
        vals = {};
        repeat (4) vals.push_back(int'($urandom_range(99, 0)));
        sendBytes(vals);                    // Display keeps old fields
        waitLine(vVisible);

        testName = "ignored bytes";
        waitLine(100);
        vals = {};
        repeat (16) vals.push_back(int'($urandom_range(99, 0)));
        sendBytes(vals);                    // Visible area, no capture
        waitLine(vVisible);
        vals = {0, 9, 10, 99};
        repeat (3) vals.push_back(int'($urandom_range(99, 0))); // Last one is the 7th
        sendBytes(vals);
        expectFields(vals);
        waitLine(vVisible);

        $display("test passed");
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", watchdogCycles);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* fontGlyphs.mem */
// One byte per glyph row, bit 7 is the leftmost pixel, 8 rows per glyph: digits 0-9, then colon
3C
66
6E
76
66
66
3C
00
18
38
18
18
18
18
7E
00
3C
66
06
0C
18
30
7E
00
3C
66
06
1C
06
66
3C
00
0C
1C
3C
6C
7E
0C
0C
00
7E
60
7C
06
06
66
3C
00
3C
60
7C
66
66
66
3C
00
7E
06
0C
18
30
30
30
00
3C
66
66
3C
66
66
3C
00
3C
66
66
3E
06
0C
38
00
00
18
18
00
18
18
00
00

/* flist.f */
rtcDisplayPkg.sv
vgaSync.sv
rtcCapture.sv
textRenderer.sv
rtcDisplay.sv
tbRtcDisplay.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbRtcDisplay
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
